/* Bender.yml */
package:
  name: test_ctrl

sources:
  - files:
      - logic/test_ctrl_pkg.sv
      - logic/tx_byte_if.sv
      - logic/frame_parser.sv
      - logic/stream_generator.sv
      - logic/out_fifo_writer.sv
      - logic/test_ctrl_top.sv
  - target: test
    files:
      - tb/test_ctrl_sva.sv
      - tb/test_ctrl_tb.sv

/* all.f */
logic/test_ctrl_pkg.sv
logic/tx_byte_if.sv
logic/frame_parser.sv
logic/stream_generator.sv
logic/out_fifo_writer.sv
logic/test_ctrl_top.sv
tb/test_ctrl_sva.sv
tb/test_ctrl_tb.sv

/* logic/frame_parser.sv */
// Reads framed commands from the input FIFO and checks them.
// Takes at most one byte every three clocks, and none while a frame of its own is pending.
// After a stop report has gone out it halts until reset.
`timescale 1ns/100ps

module frame_parser
    import test_ctrl_pkg::*;
(
    input  logic              clk,
    input  logic              reset_i,
    output logic              rd_in_fifo_en_o,
    input  logic              rd_in_fifo_empty_i,
    input  logic [BYTE_W-1:0] rd_in_fifo_data_i,
    output logic              gen_start_o,
    tx_byte_if.source         rpt_if,
    output logic              test_ok_o,
    output logic              test_fail_o
);

    logic              rd_valid;
    logic              in_payload;
    cmd_t              cmd_q;
    logic [LEN_W-1:0]  len_left;
    test_num_t         test_num;
    logic [BYTE_W-1:0] exp_data;
    logic              frame_req;
    logic [1:0]        buf_idx;
    logic              halted;
    logic [BYTE_W-1:0] frame_buf [4];

    // Queue an echo or report frame, a report also stops all further reads
    task automatic post_frame(input logic [BYTE_W-1:0] b0, input logic [BYTE_W-1:0] b1,
                              input logic [BYTE_W-1:0] b2, input logic [BYTE_W-1:0] b3,
                              input logic is_rpt);
        frame_buf[0] <= b0;
        frame_buf[1] <= b1;
        frame_buf[2] <= b2;
        frame_buf[3] <= b3;
        buf_idx      <= 2'd0;
        frame_req    <= 1'b1;
        if (is_rpt) begin
            halted <= 1'b1;
        end
    endtask

    assign rpt_if.req  = frame_req;
    assign rpt_if.data = frame_buf[buf_idx];
    // Header length equals the index of the final byte
    assign rpt_if.last = (LEN_W'(buf_idx) == frame_buf[0][LEN_W-1:0]);

    always_ff @(posedge clk or posedge reset_i) begin
        if (reset_i) begin
            rd_in_fifo_en_o <= 1'b0;
            rd_valid        <= 1'b0;
            in_payload      <= 1'b0;
            cmd_q           <= CMD_TEST_START;
            len_left        <= '0;
            test_num        <= test_num_t'(8'd0);
            exp_data        <= '0;
            gen_start_o     <= 1'b0;
            frame_req       <= 1'b0;
            buf_idx         <= 2'd0;
            halted          <= 1'b0;
            test_ok_o       <= 1'b0;
            test_fail_o     <= 1'b0;
        end else begin
            gen_start_o <= 1'b0;
            rd_valid    <= rd_in_fifo_en_o;
            // No read back to back, nor before the last byte has been decoded
            rd_in_fifo_en_o <= ~rd_in_fifo_empty_i & ~rd_in_fifo_en_o & ~rd_valid
                               & ~frame_req & ~halted;

            // ========================================
            // Header phase
            // ========================================
            if (rd_valid && !in_payload) begin
                cmd_q    <= cmd_t'(rd_in_fifo_data_i[7:6]);
                len_left <= rd_in_fifo_data_i[LEN_W-1:0];
                case (cmd_t'(rd_in_fifo_data_i[7:6]))
                    CMD_TEST_START: begin
                        if (rd_in_fifo_data_i[LEN_W-1:0] == LEN_W'(1)) begin
                            in_payload <= 1'b1;
                        end else begin
                            post_frame({CMD_TEST_STOPPED, LEN_W'(1)}, ERR_START_PAYLOAD,
                                       '0, '0, 1'b1);
                        end
                    end
                    // Empty data frames are accepted and dropped
                    CMD_TEST_DATA: in_payload <= (rd_in_fifo_data_i[LEN_W-1:0] != '0);
                    CMD_TEST_STOP: begin
                        if (rd_in_fifo_data_i[LEN_W-1:0] == '0) begin
                            post_frame({CMD_TEST_STOPPED, LEN_W'(1)}, ERR_NONE, '0, '0, 1'b1);
                        end else begin
                            post_frame({CMD_TEST_STOPPED, LEN_W'(1)}, ERR_STOP_PAYLOAD,
                                       '0, '0, 1'b1);
                        end
                    end
                    default: post_frame({CMD_TEST_STOPPED, LEN_W'(1)}, ERR_INVALID_CMD,
                                        '0, '0, 1'b1);
                endcase
            end

            // ========================================
            // Payload phase
            // ========================================
            if (rd_valid && in_payload) begin
                len_left <= len_left - LEN_W'(1);
                if (len_left == LEN_W'(1)) begin
                    in_payload <= 1'b0;
                end
                if (cmd_q == CMD_TEST_START) begin
                    test_num <= test_num_t'(rd_in_fifo_data_i);
                    exp_data <= '0;
                    case (rd_in_fifo_data_i)
                        TEST_RECEIVE, TEST_RECEIVE_SEND: ;
                        TEST_SEND: gen_start_o <= 1'b1;
                        default: post_frame({CMD_TEST_STOPPED, LEN_W'(2)}, ERR_TEST_NUM,
                                            rd_in_fifo_data_i, '0, 1'b1);
                    endcase
                end else if (rd_in_fifo_data_i == exp_data) begin
                    exp_data <= exp_data + 1'b1;
                    // Loopback echoes every good byte in a frame of its own
                    if (test_num == TEST_RECEIVE_SEND) begin
                        post_frame({CMD_TEST_DATA, LEN_W'(1)}, rd_in_fifo_data_i, '0, '0, 1'b0);
                    end
                end else begin
                    post_frame({CMD_TEST_STOPPED, LEN_W'(3)}, ERR_TEST_DATA,
                               rd_in_fifo_data_i, exp_data, 1'b1);
                end
            end

            // Hand over frame bytes, status rises with the final report byte
            if (frame_req && rpt_if.take) begin
                if (rpt_if.last) begin
                    frame_req <= 1'b0;
                    if (halted) begin
                        test_ok_o   <= (frame_buf[1] == ERR_NONE);
                        test_fail_o <= (frame_buf[1] != ERR_NONE);
                    end
                end else begin
                    buf_idx <= buf_idx + 2'd1;
                end
            end
        end
    end

endmodule

/* logic/out_fifo_writer.sv */
// Merges parser and generator frames into the output FIFO.
// Frames are never interleaved; between frames the parser wins.
// Almost-full must assert with at least one entry still free.
`timescale 1ns/100ps

module out_fifo_writer
    import test_ctrl_pkg::*;
(
    input  logic              clk,
    input  logic              reset_i,
    tx_byte_if.sink           rpt_if,
    tx_byte_if.sink           gen_if,
    output logic              wr_out_fifo_en_o,
    output logic [BYTE_W-1:0] wr_out_fifo_data_o,
    input  logic              wr_out_fifo_full_i,
    input  logic              wr_out_fifo_afull_i
);

    // Frame lock, sel_q is 1 for the generator
    logic              locked;
    logic              sel_q;
    logic              cur_sel;
    logic              cur_req;
    logic              cur_last;
    logic [BYTE_W-1:0] cur_data;
    logic              room;
    logic              take;

    // ========================================
    // Source selection
    // ========================================
    always_comb begin
        cur_sel  = locked ? sel_q : ~rpt_if.req;
        cur_req  = cur_sel ? gen_if.req : rpt_if.req;
        cur_last = cur_sel ? gen_if.last : rpt_if.last;
        cur_data = cur_sel ? gen_if.data : rpt_if.data;
    end

    assign room = ~wr_out_fifo_full_i & ~wr_out_fifo_afull_i;
    assign take = room & cur_req;

    assign rpt_if.take = take & ~cur_sel;
    assign gen_if.take = take & cur_sel;

    always_ff @(posedge clk or posedge reset_i) begin
        if (reset_i) begin
            locked           <= 1'b0;
            sel_q            <= 1'b0;
            wr_out_fifo_en_o <= 1'b0;
        end else begin
            wr_out_fifo_en_o <= take;
            if (take) begin
                // Hold the source until its last byte leaves
                locked <= ~cur_last;
                sel_q  <= cur_sel;
            end
        end
    end

    // Byte goes out one clock after its take
    always_ff @(posedge clk) begin
        if (take) begin
            wr_out_fifo_data_o <= cur_data;
        end
    end

endmodule

/* logic/stream_generator.sv */
// Counting data packets for the send test.
// PACKET_PAYLOAD must lie in 1..63; data bytes run on across packets without gaps.
// A start while packets are still going out restarts the sequence.
`timescale 1ns/100ps

module stream_generator
    import test_ctrl_pkg::*;
#(
    parameter int PACKET_PAYLOAD = DEF_PACKET_PAYLOAD,
    parameter int PACKET_COUNT   = DEF_PACKET_COUNT
) (
    input  logic      clk,
    input  logic      reset_i,
    input  logic      start_i,
    tx_byte_if.source gen_if
);

    localparam int PKT_W = $clog2(PACKET_COUNT + 1);

    logic              active;
    logic [PKT_W-1:0]  pkt_left;
    // Zero while the header is on offer
    logic [LEN_W-1:0]  byte_idx;
    logic [BYTE_W-1:0] data_cnt;
    logic              at_header;

    assign at_header = (byte_idx == '0);

    assign gen_if.req  = active;
    assign gen_if.data = at_header ? {CMD_TEST_DATA, LEN_W'(PACKET_PAYLOAD)} : data_cnt;
    assign gen_if.last = (byte_idx == LEN_W'(PACKET_PAYLOAD));

    always_ff @(posedge clk or posedge reset_i) begin
        if (reset_i) begin
            active   <= 1'b0;
            pkt_left <= '0;
            byte_idx <= '0;
            data_cnt <= '0;
        end else if (start_i) begin
            active   <= 1'b1;
            pkt_left <= PKT_W'(PACKET_COUNT);
            byte_idx <= '0;
            data_cnt <= '0;
        end else if (active && gen_if.take) begin
            if (!at_header) begin
                data_cnt <= data_cnt + 1'b1;
            end

            if (gen_if.last) begin
                // Packet done, go back to a header or stop
                byte_idx <= '0;
                pkt_left <= pkt_left - 1'b1;
                if (pkt_left == PKT_W'(1)) begin
                    active <= 1'b0;
                end
            end else begin
                byte_idx <= byte_idx + 1'b1;
            end
        end
    end

endmodule

/* logic/test_ctrl_pkg.sv */
// Shared definitions of the byte-stream test controller.
// A frame header is {cmd, length}, and the length counts the payload bytes after it.
// The STOPPED command is only ever sent by the controller.

package test_ctrl_pkg;

    // ========================================
    // Field widths
    // ========================================
    localparam int BYTE_W = 8;
    localparam int LEN_W  = 6;

    // Generator defaults, 63 bytes is the largest payload a header can describe
    localparam int DEF_PACKET_PAYLOAD = 63;
    localparam int DEF_PACKET_COUNT   = 2;

    // ========================================
    // Header command
    // ========================================
    typedef enum logic [1:0] {
        CMD_TEST_START   = 2'd0,
        CMD_TEST_DATA    = 2'd1,
        CMD_TEST_STOP    = 2'd2,
        CMD_TEST_STOPPED = 2'd3
    } cmd_t;

    // ========================================
    // Test number, carried in the start payload
    // ========================================
    typedef enum logic [7:0] {
        TEST_RECEIVE      = 8'd1,
        TEST_SEND         = 8'd2,
        TEST_RECEIVE_SEND = 8'd3
    } test_num_t;

    // Report code, first byte after a STOPPED header
    typedef enum logic [7:0] {
        ERR_NONE          = 8'd0,
        ERR_START_PAYLOAD = 8'd1,
        ERR_STOP_PAYLOAD  = 8'd2,
        ERR_INVALID_CMD   = 8'd3,
        ERR_TEST_NUM      = 8'd4,
        ERR_TEST_DATA     = 8'd5
    } err_code_t;

endpackage

/* logic/test_ctrl_top.sv */
// Byte-stream test controller, single clock domain.
// Both FIFOs are outside; the output FIFO must raise almost-full one entry early.
`timescale 1ns/100ps

module test_ctrl_top
    import test_ctrl_pkg::*;
#(
    parameter int PACKET_PAYLOAD = DEF_PACKET_PAYLOAD,
    parameter int PACKET_COUNT   = DEF_PACKET_COUNT
) (
    input  logic              clk,
    input  logic              reset_i,
    // Input FIFO
    output logic              rd_in_fifo_en_o,
    input  logic              rd_in_fifo_empty_i,
    input  logic [BYTE_W-1:0] rd_in_fifo_data_i,
    // Output FIFO
    output logic              wr_out_fifo_en_o,
    output logic [BYTE_W-1:0] wr_out_fifo_data_o,
    input  logic              wr_out_fifo_full_i,
    input  logic              wr_out_fifo_afull_i,
    // Status levels
    output logic              test_ok_o,
    output logic              test_fail_o
);

    logic gen_start;

    tx_byte_if rpt_if ();
    tx_byte_if gen_if ();

    frame_parser parser_i (
        .clk                (clk),
        .reset_i            (reset_i),
        .rd_in_fifo_en_o    (rd_in_fifo_en_o),
        .rd_in_fifo_empty_i (rd_in_fifo_empty_i),
        .rd_in_fifo_data_i  (rd_in_fifo_data_i),
        .gen_start_o        (gen_start),
        .rpt_if             (rpt_if.source),
        .test_ok_o          (test_ok_o),
        .test_fail_o        (test_fail_o)
    );

    stream_generator #(
        .PACKET_PAYLOAD (PACKET_PAYLOAD),
        .PACKET_COUNT   (PACKET_COUNT)
    ) generator_i (
        .clk     (clk),
        .reset_i (reset_i),
        .start_i (gen_start),
        .gen_if  (gen_if.source)
    );

    out_fifo_writer writer_i (
        .clk                 (clk),
        .reset_i             (reset_i),
        .rpt_if              (rpt_if.sink),
        .gen_if              (gen_if.sink),
        .wr_out_fifo_en_o    (wr_out_fifo_en_o),
        .wr_out_fifo_data_o  (wr_out_fifo_data_o),
        .wr_out_fifo_full_i  (wr_out_fifo_full_i),
        .wr_out_fifo_afull_i (wr_out_fifo_afull_i)
    );

endmodule

/* logic/tx_byte_if.sv */
// One frame byte offered by a source to the output writer.
// The source holds req, data and last until take; take is a single-cycle pulse.
`timescale 1ns/100ps

interface tx_byte_if
    import test_ctrl_pkg::*;
();

    logic              req;
    logic [BYTE_W-1:0] data;
    logic              last;
    logic              take;

    // Parser or generator side
    modport source (
        output req, data, last,
        input  take
    );

    // Writer side
    modport sink (
        input  req, data, last,
        output take
    );

endinterface

/* tb/test_ctrl_sva.sv */
// Assertions on the FIFO strobes and status levels of the controller.
// Expects the output FIFO flags to be registered, as in the testbench model.
`timescale 1ns/100ps

module test_ctrl_sva (
    input logic clk,
    input logic reset_i,
    input logic rd_in_fifo_en_o,
    input logic rd_in_fifo_empty_i,
    input logic wr_out_fifo_en_o,
    input logic wr_out_fifo_full_i,
    input logic wr_out_fifo_afull_i,
    input logic test_ok_o,
    input logic test_fail_o
);

    // Number of assertion failures so far
    int fail_count = 0;

    // ========================================
    // Input FIFO reads
    // ========================================
    rd_not_empty: assert property (@(posedge clk) disable iff (reset_i)
        rd_in_fifo_en_o |-> !rd_in_fifo_empty_i)
        else begin
            fail_count++;
            $error("input FIFO read while empty");
        end

    rd_no_burst: assert property (@(posedge clk) disable iff (reset_i)
        rd_in_fifo_en_o |=> !rd_in_fifo_en_o)
        else begin
            fail_count++;
            $error("input FIFO read in two consecutive cycles");
        end

    // Write one clock after a take, which needs room
    wr_has_room: assert property (@(posedge clk) disable iff (reset_i)
        wr_out_fifo_en_o |-> $past(!wr_out_fifo_full_i && !wr_out_fifo_afull_i))
        else begin
            fail_count++;
            $error("output FIFO written without room");
        end

    status_excl: assert property (@(posedge clk) disable iff (reset_i)
        !(test_ok_o && test_fail_o))
        else begin
            fail_count++;
            $error("ok and fail high together");
        end

    reset_quiet: assert property (@(posedge clk)
        reset_i |-> !rd_in_fifo_en_o && !wr_out_fifo_en_o && !test_ok_o && !test_fail_o)
        else begin
            fail_count++;
            $error("control output active during reset");
        end

endmodule

bind test_ctrl_top test_ctrl_sva sva_i (
    .clk                 (clk),
    .reset_i             (reset_i),
    .rd_in_fifo_en_o     (rd_in_fifo_en_o),
    .rd_in_fifo_empty_i  (rd_in_fifo_empty_i),
    .wr_out_fifo_en_o    (wr_out_fifo_en_o),
    .wr_out_fifo_full_i  (wr_out_fifo_full_i),
    .wr_out_fifo_afull_i (wr_out_fifo_afull_i),
    .test_ok_o           (test_ok_o),
    .test_fail_o         (test_fail_o)
);

/* tb/test_ctrl_tb.sv */
// Testbench with FIFO models on both sides of the controller.
// Output FIFO holds 16 bytes, raises almost-full at 14 and drains on random cycles.
// Stimulus is queued at the falling edge, the FIFO models work on the rising edge.
`timescale 1ns/100ps

module test_ctrl_tb
    import test_ctrl_pkg::*;
();

    localparam int OUT_DEPTH   = 16;
    localparam int OUT_AFULL   = 14;
    localparam int TIMEOUT     = 4000;
    localparam int HALT_WINDOW = 60;

    logic              clk, reset_i;
    logic              rd_in_fifo_en_o, rd_in_fifo_empty_i;
    logic [BYTE_W-1:0] rd_in_fifo_data_i, wr_out_fifo_data_o;
    logic              wr_out_fifo_en_o, wr_out_fifo_full_i, wr_out_fifo_afull_i;
    logic              test_ok_o, test_fail_o;

    logic [31:0]       lfsr_q = 32'h5925_f3d7;
    logic [BYTE_W-1:0] in_q[$], out_q[$], got_q[$], exp_q[$];
    int                rd_count, errors, tests, failed_tests, err_at_start;
    logic              timed_out = 1'b0;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    test_ctrl_top #(
        .PACKET_PAYLOAD (DEF_PACKET_PAYLOAD),
        .PACKET_COUNT   (DEF_PACKET_COUNT)
    ) dut_i (.*);

    // Testbench errors plus failed assertions of the bound checker
    function automatic int error_count();
        return errors + dut_i.sva_i.fail_count;
    endfunction

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr_bit());
        end
        return v;
    endfunction

    function automatic logic [BYTE_W-1:0] header(input cmd_t cmd, input int len);
        return {cmd, LEN_W'(len)};
    endfunction

    // ========================================
    // FIFO models
    // ========================================
    always @(posedge clk) begin
        if (rd_in_fifo_en_o && in_q.size() > 0) begin
            rd_in_fifo_data_i <= in_q.pop_front();
            rd_count++;
        end
        rd_in_fifo_empty_i <= (in_q.size() == 0);
    end

    always @(posedge clk) begin
        if (wr_out_fifo_en_o) begin
            if (out_q.size() >= OUT_DEPTH) begin
                $display("error at %0t: byte written into a full output FIFO", $time);
                errors++;
            end
            out_q.push_back(wr_out_fifo_data_o);
        end
        // Drain about one cycle in four to build back-pressure
        if (out_q.size() > 0 && rand_bits(2) == 3)
            got_q.push_back(out_q.pop_front());
        wr_out_fifo_full_i  <= (out_q.size() >= OUT_DEPTH);
        wr_out_fifo_afull_i <= (out_q.size() >= OUT_AFULL);
    end

    task automatic check_eq(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
            errors++;
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        reset_i <= 1'b1;
        @(negedge clk);
        in_q.delete();
        out_q.delete();
        got_q.delete();
        exp_q.delete();
        err_at_start = error_count();
        repeat (8) @(posedge clk);
        reset_i <= 1'b0;
        @(negedge clk);
    endtask

    task automatic wait_bytes(input int n, input string what);
        int cycles;
        cycles = 0;
        while (!timed_out && got_q.size() < n) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("timeout in %s: only %0d of %0d output bytes arrived",
                         what, got_q.size(), n);
                timed_out = 1'b1;
                errors++;
            end
        end
    endtask

    task automatic expect_report(input err_code_t code, input int n_extra,
                                 input logic [BYTE_W-1:0] x1, input logic [BYTE_W-1:0] x2);
        exp_q.push_back(header(CMD_TEST_STOPPED, 1 + n_extra));
        exp_q.push_back(code);
        if (n_extra > 0)
            exp_q.push_back(x1);
        if (n_extra > 1)
            exp_q.push_back(x2);
    endtask

    // After a report the input must stay untouched and nothing more may come out
    task automatic check_halt();
        int reads;
        int outs;
        int pending;
        in_q.push_back(header(CMD_TEST_START, 1));
        in_q.push_back(TEST_RECEIVE);
        reads   = rd_count;
        outs    = got_q.size() + out_q.size();
        pending = in_q.size();
        repeat (HALT_WINDOW) @(negedge clk);
        check_eq("input reads after halt", rd_count, reads);
        check_eq("input FIFO count", in_q.size(), pending);
        check_eq("output bytes after halt", got_q.size() + out_q.size(), outs);
    endtask

    task automatic finish_test(input string name, input logic pass_exp);
        wait_bytes(exp_q.size(), name);
        if (!timed_out) begin
            check_eq("output byte count", got_q.size(), exp_q.size());
            for (int i = 0; i < exp_q.size(); i++) begin
                check_eq($sformatf("wr_out_fifo_data_o[%0d]", i), got_q[i], exp_q[i]);
            end
            check_eq("test_ok_o", test_ok_o, pass_exp);
            check_eq("test_fail_o", test_fail_o, !pass_exp);
            check_halt();
        end
        tests++;
        if (error_count() != err_at_start)
            failed_tests++;
        $display("test %s %s", name, (error_count() == err_at_start) ? "passed" : "failed");
    endtask

    // ========================================
    // Tests
    // ========================================
    task automatic run_loopback();
        int len;
        int cnt;
        int n_frames;
        cnt = 0;
        apply_reset();
        in_q.push_back(header(CMD_TEST_START, 1));
        in_q.push_back(TEST_RECEIVE_SEND);
        n_frames = 2 + rand_bits(2);
        for (int f = 0; f < n_frames; f++) begin
            len = 1 + rand_bits(4);
            in_q.push_back(header(CMD_TEST_DATA, len));
            for (int i = 0; i < len; i++) begin
                in_q.push_back(BYTE_W'(cnt));
                exp_q.push_back(header(CMD_TEST_DATA, 1));
                exp_q.push_back(BYTE_W'(cnt));
                cnt++;
            end
        end
        // Empty data frame is dropped
        in_q.push_back(header(CMD_TEST_DATA, 0));
        in_q.push_back(header(CMD_TEST_STOP, 0));
        expect_report(ERR_NONE, 0, '0, '0);
        finish_test("loopback", 1'b1);
    endtask

    task automatic run_send();
        int cnt;
        cnt = 0;
        apply_reset();
        in_q.push_back(header(CMD_TEST_START, 1));
        in_q.push_back(TEST_SEND);
        for (int p = 0; p < DEF_PACKET_COUNT; p++) begin
            exp_q.push_back(header(CMD_TEST_DATA, DEF_PACKET_PAYLOAD));
            for (int i = 0; i < DEF_PACKET_PAYLOAD; i++) begin
                exp_q.push_back(BYTE_W'(cnt));
                cnt++;
            end
        end
        wait_bytes(exp_q.size(), "send packets");
        in_q.push_back(header(CMD_TEST_STOP, 0));
        expect_report(ERR_NONE, 0, '0, '0);
        finish_test("send", 1'b1);
    endtask

    task automatic run_bad_data();
        int len;
        int cnt;
        int pos;
        logic [BYTE_W-1:0] bad;
        cnt = 0;
        pos = rand_bits(5);
        bad = BYTE_W'(pos) ^ BYTE_W'(1 + rand_bits(7));
        apply_reset();
        in_q.push_back(header(CMD_TEST_START, 1));
        in_q.push_back(TEST_RECEIVE);
        // Two frames of at least 16 bytes always reach the bad position
        for (int f = 0; f < 2; f++) begin
            len = 16 + rand_bits(4);
            in_q.push_back(header(CMD_TEST_DATA, len));
            for (int i = 0; i < len; i++) begin
                in_q.push_back((cnt == pos) ? bad : BYTE_W'(cnt));
                cnt++;
            end
        end
        in_q.push_back(header(CMD_TEST_STOP, 0));
        expect_report(ERR_TEST_DATA, 2, bad, BYTE_W'(pos));
        finish_test("bad data", 1'b0);
    endtask

    task automatic run_header_error(input int which);
        string name;
        apply_reset();
        case (which)
            0: begin
                name = "start length";
                in_q = '{header(CMD_TEST_START, 2), TEST_RECEIVE, TEST_RECEIVE};
                expect_report(ERR_START_PAYLOAD, 0, '0, '0);
            end
            1: begin
                name = "stop payload";
                in_q = '{header(CMD_TEST_STOP, 1), 8'h00};
                expect_report(ERR_STOP_PAYLOAD, 0, '0, '0);
            end
            2: begin
                name = "stopped cmd";
                in_q = '{header(CMD_TEST_STOPPED, 0)};
                expect_report(ERR_INVALID_CMD, 0, '0, '0);
            end
            default: begin
                name = "test number";
                in_q = '{header(CMD_TEST_START, 1), 8'd9};
                expect_report(ERR_TEST_NUM, 1, 8'd9, '0);
            end
        endcase
        finish_test(name, 1'b0);
    endtask

    initial begin
        reset_i             <= 1'b1;
        rd_in_fifo_empty_i  <= 1'b1;
        rd_in_fifo_data_i   <= '0;
        wr_out_fifo_full_i  <= 1'b0;
        wr_out_fifo_afull_i <= 1'b0;
        run_loopback();
        run_send();
        run_bad_data();
        for (int k = 0; k < 4; k++) begin
            run_header_error(k);
        end
        $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, error_count());
        if (error_count() == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
